/* tb.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/cla_adder.sv
hdl/ex_decoder.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/ex_merge.sv
hdl/ex_stage.sv
dv/ex_stage_tb.sv

/* dv/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 2000;
    localparam int MAX_CYCLES   = RESET_CYCLES + 184 + N_RANDOM + 200;

    logic     clk = 1'b0;
    logic     rst_n;
    ex_req_t  req;
    ex_resp_t resp;
    ex_resp_t exp_q;
    int       cycle = 0;
    int       errors = 0;

    ex_stage dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .resp  (resp)
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] lui_value(input logic [63:0] imm);
        return {{32{imm[19]}}, imm[19:0], 12'h000};
    endfunction

    // Register result of OP, OP-IMM and their word forms
    function automatic logic [63:0] arith_result(input ex_req_t r);
        logic        is_imm;
        logic        is_word;
        logic        legal;
        logic [6:0]  f7;
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        logic [63:0] y;
        is_imm  = (r.opcode == `OPC_OP_IMM) || (r.opcode == `OPC_OP_IMM_32);
        is_word = (r.opcode == `OPC_OP_32) || (r.opcode == `OPC_OP_IMM_32);
        // shamt[5] of an immediate shift sits in func7[0]
        f7    = is_imm ? {r.func7[6:1], 1'b0} : r.func7;
        legal = 1'b1;
        y     = '0;
        a     = is_word ? sext32(r.data1[31:0]) : r.data1;
        b     = is_imm ? r.imm : r.data2;
        b     = is_word ? sext32(b[31:0]) : b;
        sh    = is_word ? {1'b0, b[4:0]} : b[5:0];
        case (r.func3)
            `F3_ADD: begin
                if (is_imm || f7 == `F7_BASE) begin
                    y = a + b;
                end else if (f7 == `F7_ALT) begin
                    y = a - b;
                end else begin
                    legal = 1'b0;
                end
            end
            `F3_SLL: begin
                legal = (f7 == `F7_BASE);
                y     = a << sh;
            end
            `F3_SR: begin
                legal = (f7 == `F7_BASE) || (f7 == `F7_ALT);
                if (f7 == `F7_ALT) begin
                    y = $signed(a) >>> sh;
                end else begin
                    y = is_word ? ({32'd0, a[31:0]} >> sh) : (a >> sh);
                end
            end
            default: begin
                legal = is_imm || (f7 == `F7_BASE);
                case (r.func3)
                    `F3_SLT:  y = {63'd0, $signed(a) < $signed(b)};
                    `F3_SLTU: y = {63'd0, a < b};
                    `F3_XOR:  y = a ^ b;
                    `F3_OR:   y = a | b;
                    default:  y = a & b;
                endcase
            end
        endcase
        if (!legal) begin
            return 64'd0;
        end
        return is_word ? sext32(y[31:0]) : y;
    endfunction

    function automatic ex_resp_t model_resp(input ex_req_t r);
        ex_resp_t e;
        logic     cond;
        e           = '0;
        e.pc_branch = r.pc + 32'd4;
        case (r.opcode)
            `OPC_OP, `OPC_OP_32, `OPC_OP_IMM, `OPC_OP_IMM_32: e.result = arith_result(r);
            `OPC_LUI:   e.result = lui_value(r.imm);
            `OPC_AUIPC: e.result = {32'd0, r.pc} + lui_value(r.imm);
            `OPC_LOAD:  e.is_load = 1'b1;
            `OPC_STORE: e.mem_rw = 1'b1;
            `OPC_BRANCH: begin
                case (r.func3)
                    `F3_BEQ:  cond = (r.data1 == r.data2);
                    `F3_BNE:  cond = (r.data1 != r.data2);
                    `F3_BLT:  cond = ($signed(r.data1) < $signed(r.data2));
                    `F3_BGE:  cond = ($signed(r.data1) >= $signed(r.data2));
                    `F3_BLTU: cond = (r.data1 < r.data2);
                    `F3_BGEU: cond = (r.data1 >= r.data2);
                    default:  cond = 1'b0;
                endcase
                if (cond) begin
                    e.is_branch = 1'b1;
                    e.pc_branch = r.pc + r.imm[31:0];
                end
            end
            `OPC_JAL: begin
                e.is_branch = 1'b1;
                e.pc_branch = r.pc + r.imm[31:0];
            end
            `OPC_JALR: begin
                e.is_branch = 1'b1;
                e.pc_branch = r.data1[31:0] + r.imm[31:0];
            end
            default: ;
        endcase
        return e;
    endfunction

    // Expected response lines up with the DUT register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= '0;
        end else begin
            exp_q <= model_resp(req);
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        errors++;
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    reset_zero: assert property (@(posedge clk) (!rst_n && cycle != 0) |-> resp == '0)
        else report_mismatch("resp in reset", '0, $sampled(resp.result));
    first_zero: assert property (@(posedge clk) $rose(rst_n) |-> resp == '0)
        else report_mismatch("resp after reset", '0, $sampled(resp.result));
    chk_result: assert property (@(posedge clk) disable iff (!rst_n)
                                 resp.result == exp_q.result)
        else report_mismatch("result", $sampled(exp_q.result), $sampled(resp.result));
    chk_pc: assert property (@(posedge clk) disable iff (!rst_n)
                             resp.pc_branch == exp_q.pc_branch)
        else report_mismatch("pc_branch", $sampled(exp_q.pc_branch), $sampled(resp.pc_branch));
    chk_branch: assert property (@(posedge clk) disable iff (!rst_n)
                                 resp.is_branch == exp_q.is_branch)
        else report_mismatch("is_branch", $sampled(exp_q.is_branch), $sampled(resp.is_branch));
    chk_rw: assert property (@(posedge clk) disable iff (!rst_n) resp.mem_rw == exp_q.mem_rw)
        else report_mismatch("mem_rw", $sampled(exp_q.mem_rw), $sampled(resp.mem_rw));
    chk_load: assert property (@(posedge clk) disable iff (!rst_n) resp.is_load == exp_q.is_load)
        else report_mismatch("is_load", $sampled(exp_q.is_load), $sampled(resp.is_load));

    function automatic ex_req_t make_req(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [6:0] f7, input logic [63:0] imm,
                                         input logic [63:0] d1, input logic [63:0] d2,
                                         input logic [31:0] pc);
        ex_req_t r;
        r = '{opcode: opc, func3: f3, func7: f7, imm: imm, data1: d1, data2: d2, pc: pc};
        return r;
    endfunction

    task automatic drive_req(input ex_req_t r);
        @(posedge clk);
        req <= r;
    endtask

    task automatic run_directed();
        logic [63:0] sh_d1;
        logic [63:0] amt;
        logic [6:0]  s5;
        logic [2:0]  br_f3 [6];
        logic [63:0] br_a [5];
        logic [63:0] br_b [5];
        int          amts [4];
        sh_d1 = 64'h8000_0001_8000_0001;
        amts  = '{0, 31, 32, 63};
        br_f3 = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
        br_a  = '{64'd5, 64'd1, 64'd2, '1, 64'd1};
        br_b  = '{64'd5, 64'd2, 64'd1, 64'd1, '1};
        // Overflow and sign boundaries
        drive_req(make_req(`OPC_OP, `F3_ADD, `F7_BASE, 0, 64'h7fff_ffff_ffff_ffff, 64'd1, 0));
        drive_req(make_req(`OPC_OP, `F3_ADD, `F7_BASE, 0, '1, 64'd1, 0));
        drive_req(make_req(`OPC_OP, `F3_ADD, `F7_ALT, 0, 64'h8000_0000_0000_0000, 64'd1, 0));
        drive_req(make_req(`OPC_OP, `F3_ADD, `F7_ALT, 0, 64'd0, 64'd1, 0));
        drive_req(make_req(`OPC_OP_IMM, `F3_ADD, `F7_BASE, '1, 64'd0, 64'd0, 0));
        drive_req(make_req(`OPC_OP, `F3_SLT, `F7_BASE, 0, '1, 64'd1, 0));
        drive_req(make_req(`OPC_OP, `F3_SLTU, `F7_BASE, 0, '1, 64'd1, 0));
        drive_req(make_req(`OPC_OP, `F3_SLT, `F7_BASE, 0, 64'h8000_0000_0000_0000,
                           64'h7fff_ffff_ffff_ffff, 0));
        drive_req(make_req(`OPC_OP_IMM, `F3_SLTU, `F7_BASE, '1, 64'd3, 0, 0));
        drive_req(make_req(`OPC_OP_IMM, `F3_SLT, `F7_BASE, '1, 64'd3, 0, 0));
        drive_req(make_req(`OPC_OP, `F3_XOR, `F7_BASE, 0, sh_d1, '1, 0));
        drive_req(make_req(`OPC_OP_IMM, `F3_OR, `F7_BASE, 64'h7f0, sh_d1, 0, 0));
        drive_req(make_req(`OPC_OP, `F3_AND, `F7_BASE, 0, sh_d1, 64'hffff_0000_ffff_0000, 0));
        for (int i = 0; i < 4; i++) begin
            amt = 64'(amts[i]);
            s5  = {6'd0, amt[5]};
            drive_req(make_req(`OPC_OP, `F3_SLL, `F7_BASE, 0, sh_d1, amt, 0));
            drive_req(make_req(`OPC_OP, `F3_SR, `F7_BASE, 0, sh_d1, amt, 0));
            drive_req(make_req(`OPC_OP, `F3_SR, `F7_ALT, 0, sh_d1, amt, 0));
            drive_req(make_req(`OPC_OP_IMM, `F3_SLL, `F7_BASE | s5, amt, sh_d1, 0, 0));
            drive_req(make_req(`OPC_OP_IMM, `F3_SR, `F7_BASE | s5, amt, sh_d1, 0, 0));
            drive_req(make_req(`OPC_OP_IMM, `F3_SR, `F7_ALT | s5, amt, sh_d1, 0, 0));
            // Word shifts ignore amount bit 5
            drive_req(make_req(`OPC_OP_32, `F3_SLL, `F7_BASE, 0, sh_d1, amt, 0));
            drive_req(make_req(`OPC_OP_32, `F3_SR, `F7_BASE, 0, sh_d1, amt, 0));
            drive_req(make_req(`OPC_OP_32, `F3_SR, `F7_ALT, 0, sh_d1, amt, 0));
            drive_req(make_req(`OPC_OP_IMM_32, `F3_SLL, `F7_BASE, amt & 31, sh_d1, 0, 0));
            drive_req(make_req(`OPC_OP_IMM_32, `F3_SR, `F7_BASE, amt & 31, sh_d1, 0, 0));
            drive_req(make_req(`OPC_OP_IMM_32, `F3_SR, `F7_ALT, amt & 31, sh_d1, 0, 0));
        end
        drive_req(make_req(`OPC_OP_32, `F3_ADD, `F7_BASE, 0, 64'hdead_beef_7fff_ffff,
                           64'h1234_5678_0000_0001, 0));
        drive_req(make_req(`OPC_OP_32, `F3_ADD, `F7_ALT, 0, 64'hdead_beef_0000_0000,
                           64'h1234_5678_0000_0001, 0));
        drive_req(make_req(`OPC_OP_IMM_32, `F3_ADD, `F7_BASE, '1, 64'hffff_0000_8000_0000, 0, 0));
        drive_req(make_req(`OPC_LUI, 3'd0, 7'd0, 64'h8_0000, 0, 0, 0));
        drive_req(make_req(`OPC_LUI, 3'd0, 7'd0, 64'h1_2345, 0, 0, 0));
        drive_req(make_req(`OPC_AUIPC, 3'd0, 7'd0, 64'h8_0000, 0, 0, 32'h8000_0000));
        drive_req(make_req(`OPC_AUIPC, 3'd0, 7'd0, 64'h0_0001, 0, 0, 32'h0000_1004));
        // Each branch at equal, less and greater, signed and unsigned
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 5; p++) begin
                drive_req(make_req(`OPC_BRANCH, br_f3[f], 7'd0, 64'hffff_ffff_ffff_fff0,
                                   br_a[p], br_b[p], 32'h1000 + 32'(f * 64 + p * 8)));
            end
        end
        drive_req(make_req(`OPC_BRANCH, 3'b010, 7'd0, 64'h40, 64'd1, 64'd1, 32'h2000));
        drive_req(make_req(`OPC_JAL, 3'd0, 7'd0, 64'h800, 0, 0, 32'h4000));
        drive_req(make_req(`OPC_JAL, 3'd0, 7'd0, '1 << 3, 0, 0, 32'h4));
        drive_req(make_req(`OPC_JALR, 3'd0, 7'd0, '1 << 2, 64'h2000_0010, 0, 32'h5000));
        drive_req(make_req(`OPC_JALR, 3'd0, 7'd0, 64'h10, 64'hffff_0000_0000_1000, 0, 32'h6));
        drive_req(make_req(`OPC_LOAD, 3'd3, 7'd0, 64'h8, 64'h100, 64'h55, 32'h7000));
        drive_req(make_req(`OPC_STORE, 3'd3, 7'd0, 64'h8, 64'h100, 64'h55, 32'h7004));
        drive_req(make_req(7'h00, 3'd0, 7'd0, 64'h1, '1, '1, 32'h7008));
        drive_req(make_req(7'h7f, 3'd7, 7'h7f, '1, '1, '1, 32'hffff_fffc));
        // mul encoding is not supported
        drive_req(make_req(`OPC_OP, `F3_ADD, 7'h01, 0, 64'd3, 64'd5, 32'h700c));
    endtask

    task automatic run_random(input int n);
        logic [6:0]  opcs [11];
        logic [11:0] i12;
        ex_req_t     r;
        int          k;
        opcs = '{`OPC_OP, `OPC_OP_32, `OPC_OP_IMM, `OPC_OP_IMM_32, `OPC_LOAD, `OPC_STORE,
                 `OPC_BRANCH, `OPC_JAL, `OPC_JALR, `OPC_AUIPC, `OPC_LUI};
        for (int i = 0; i < n; i++) begin
            k        = $urandom_range(0, 12);
            r.opcode = (k < 11) ? opcs[k] : 7'($urandom);
            r.func3  = 3'($urandom);
            case ($urandom_range(0, 7))
                0, 1, 2, 3: r.func7 = `F7_BASE;
                4, 5:       r.func7 = `F7_ALT;
                6:          r.func7 = `F7_BASE | 7'd1;
                default:    r.func7 = 7'($urandom);
            endcase
            i12   = 12'($urandom);
            r.imm = ($urandom_range(0, 3) == 0) ? {$urandom, $urandom} : {{52{i12[11]}}, i12};
            r.data1 = {$urandom, $urandom};
            r.data2 = ($urandom_range(0, 3) == 0) ? r.data1 : {$urandom, $urandom};
            r.pc    = $urandom;
            drive_req(r);
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h839a_fc3b));
        rst_n = 1'b0;
        req   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        run_directed();
        run_random(N_RANDOM);
        drive_req('0);
        repeat (3) @(posedge clk);
        $display("run complete after %0d cycles, %0d errors", cycle, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  ex_pkg::ex_req_t  req,
    output ex_pkg::ex_resp_t resp
);
    import ex_pkg::*;

    ex_ctrl_t         ctrl;
    logic [`XLEN-1:0] alu_result;
    logic             taken;
    logic [`PC_W-1:0] target;

    ex_decoder u_dec (
        .opcode (req.opcode),
        .func3  (req.func3),
        .func7  (req.func7),
        .ctrl   (ctrl)
    );

    // ALU and branch unit run side by side
    int_alu u_alu (
        .req        (req),
        .ctrl       (ctrl),
        .alu_result (alu_result)
    );

    branch_unit u_br (
        .req    (req),
        .ctrl   (ctrl),
        .taken  (taken),
        .target (target)
    );

    ex_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .taken      (taken),
        .target     (target),
        .resp       (resp)
    );

endmodule

`default_nettype wire

/* hdl/ex_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_merge (
    input  logic             clk,
    input  logic             rst_n,
    input  ex_pkg::ex_ctrl_t ctrl,
    input  logic [`XLEN-1:0] alu_result,
    input  logic             taken,
    input  logic [`PC_W-1:0] target,
    output ex_pkg::ex_resp_t resp
);
    import ex_pkg::*;

    logic [`XLEN-1:0] result_d;

    // Only instructions with a register result write one
    assign result_d = (ctrl.alu_fn == alu_none) ? '0 : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp <= '0;
        end else begin
            resp.result    <= result_d;
            resp.pc_branch <= target;
            resp.is_branch <= taken;
            resp.mem_rw    <= ctrl.is_store;
            resp.is_load   <= ctrl.is_load;
        end
    end

    // A memory access is a read or a write, never both
    mem_dir_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(resp.mem_rw && resp.is_load)
    ) else $error("ex_merge: mem_rw and is_load both high");

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module branch_unit (
    input  ex_pkg::ex_req_t  req,
    input  ex_pkg::ex_ctrl_t ctrl,
    output logic             taken,
    output logic [`PC_W-1:0] target
);
    import ex_pkg::*;

    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] tgt_sum;
    logic [`PC_W-1:0] pc_next;
    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic             cond;

    // JALR jumps relative to rs1, everything else to pc
    assign base = ctrl.is_jalr ? req.data1 : {{(`XLEN-`PC_W){1'b0}}, req.pc};

    cla_adder u_tgt (
        .a   (base),
        .b   (req.imm),
        .cin (1'b0),
        .sum (tgt_sum)
    );

    assign eq   = (req.data1 == req.data2);
    assign lt_s = ($signed(req.data1) < $signed(req.data2));
    assign lt_u = (req.data1 < req.data2);

    always_comb begin
        case (req.func3)
            `F3_BEQ:  cond = eq;
            `F3_BNE:  cond = !eq;
            `F3_BLT:  cond = lt_s;
            `F3_BGE:  cond = !lt_s;
            `F3_BLTU: cond = lt_u;
            `F3_BGEU: cond = !lt_u;
            default:  cond = 1'b0;
        endcase
    end

    assign taken = ctrl.is_jal || ctrl.is_jalr || (ctrl.cond_branch && cond);

    assign pc_next = req.pc + `PC_W'd4;

    // Fall-through also covers non-branch instructions
    assign target = taken ? tgt_sum[`PC_W-1:0] : pc_next;

endmodule

`default_nettype wire

/* hdl/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module int_alu (
    input  ex_pkg::ex_req_t  req,
    input  ex_pkg::ex_ctrl_t ctrl,
    output logic [`XLEN-1:0] alu_result
);
    import ex_pkg::*;

    localparam int HALF = `XLEN / 2;

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] a_w;
    logic [`XLEN-1:0] b_w;
    logic [`XLEN-1:0] a_zx;
    logic [`XLEN-1:0] lui_val;
    logic [`XLEN-1:0] add_a;
    logic [`XLEN-1:0] add_b;
    logic [`XLEN-1:0] add_sum;
    logic [`XLEN-1:0] raw;
    logic [5:0]       shamt;
    logic             is_sub;
    logic             is_auipc;

    assign op_b = ctrl.use_imm ? req.imm : req.data2;

    // Word forms only see the low half
    assign a_w  = ctrl.word ? {{HALF{req.data1[HALF-1]}}, req.data1[HALF-1:0]} : req.data1;
    assign b_w  = ctrl.word ? {{HALF{op_b[HALF-1]}}, op_b[HALF-1:0]} : op_b;
    assign a_zx = ctrl.word ? {{HALF{1'b0}}, req.data1[HALF-1:0]} : req.data1;

    assign shamt = ctrl.word ? {1'b0, op_b[4:0]} : op_b[5:0];

    assign lui_val = {{(`XLEN-32){req.imm[19]}}, req.imm[19:0], 12'b0};

    assign is_sub   = (ctrl.alu_fn == alu_sub);
    assign is_auipc = (ctrl.alu_fn == alu_auipc);

    // One adder for add, sub and auipc
    assign add_a = is_auipc ? {{(`XLEN-`PC_W){1'b0}}, req.pc} : a_w;

    always_comb begin
        if (is_sub) begin
            add_b = ~b_w;
        end else if (is_auipc) begin
            add_b = lui_val;
        end else begin
            add_b = b_w;
        end
    end

    cla_adder u_add (
        .a   (add_a),
        .b   (add_b),
        .cin (is_sub),
        .sum (add_sum)
    );

    always_comb begin
        case (ctrl.alu_fn)
            alu_add, alu_sub, alu_auipc: raw = add_sum;
            alu_sll:  raw = a_w << shamt;
            alu_srl:  raw = a_zx >> shamt;
            alu_sra:  raw = $signed(a_w) >>> shamt;
            alu_slt:  raw = {{(`XLEN-1){1'b0}}, $signed(a_w) < $signed(b_w)};
            alu_sltu: raw = {{(`XLEN-1){1'b0}}, a_w < b_w};
            alu_xor:  raw = a_w ^ b_w;
            alu_or:   raw = a_w | b_w;
            alu_and:  raw = a_w & b_w;
            alu_lui:  raw = lui_val;
            default:  raw = '0;
        endcase
    end

    // 32-bit result widened back to XLEN
    assign alu_result = ctrl.word ? {{HALF{raw[HALF-1]}}, raw[HALF-1:0]} : raw;

endmodule

`default_nettype wire

/* hdl/ex_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_decoder (
    input  logic [6:0]       opcode,
    input  logic [2:0]       func3,
    input  logic [6:0]       func7,
    output ex_pkg::ex_ctrl_t ctrl
);
    import ex_pkg::*;

    logic    is_imm;
    logic    is_word;
    logic    base_ok;
    logic [6:0] f7;
    alu_fn_e arith_fn;

    assign is_imm  = (opcode == `OPC_OP_IMM) || (opcode == `OPC_OP_IMM_32);
    assign is_word = (opcode == `OPC_OP_32) || (opcode == `OPC_OP_IMM_32);

    // Immediate shifts keep shamt[5] in func7[0]
    assign f7 = is_imm ? {func7[6:1], 1'b0} : func7;

    // Immediate forms carry no func7 outside the shifts
    assign base_ok = is_imm || (func7 == `F7_BASE);

    always_comb begin
        arith_fn = alu_none;
        case (func3)
            `F3_ADD: begin
                if (base_ok) begin
                    arith_fn = alu_add;
                end else if (func7 == `F7_ALT) begin
                    arith_fn = alu_sub;
                end
            end
            `F3_SLL: begin
                if (f7 == `F7_BASE) begin
                    arith_fn = alu_sll;
                end
            end
            `F3_SR: begin
                if (f7 == `F7_BASE) begin
                    arith_fn = alu_srl;
                end else if (f7 == `F7_ALT) begin
                    arith_fn = alu_sra;
                end
            end
            `F3_SLT:  arith_fn = base_ok ? alu_slt  : alu_none;
            `F3_SLTU: arith_fn = base_ok ? alu_sltu : alu_none;
            `F3_XOR:  arith_fn = base_ok ? alu_xor  : alu_none;
            `F3_OR:   arith_fn = base_ok ? alu_or   : alu_none;
            `F3_AND:  arith_fn = base_ok ? alu_and  : alu_none;
            default:  arith_fn = alu_none;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_fn = alu_none;
        case (opcode)
            `OPC_OP, `OPC_OP_32, `OPC_OP_IMM, `OPC_OP_IMM_32: begin
                ctrl.alu_fn  = arith_fn;
                ctrl.word    = is_word && (arith_fn != alu_none);
                ctrl.use_imm = is_imm && (arith_fn != alu_none);
            end
            `OPC_LUI:   ctrl.alu_fn = alu_lui;
            `OPC_AUIPC: ctrl.alu_fn = alu_auipc;
            `OPC_LOAD:  ctrl.is_load = 1'b1;
            `OPC_STORE: ctrl.is_store = 1'b1;
            `OPC_BRANCH: begin
                // 010 and 011 are not branches
                ctrl.cond_branch = (func3 != 3'b010) && (func3 != 3'b011);
            end
            `OPC_JAL:  ctrl.is_jal = 1'b1;
            `OPC_JALR: ctrl.is_jalr = 1'b1;
            default: ;
        endcase
    end

    one_class: assert final ($onehot0({ctrl.is_load, ctrl.is_store, ctrl.cond_branch,
                                       ctrl.is_jal, ctrl.is_jalr}))
        else $error("ex_decoder: more than one class flag for opcode %b", opcode);

endmodule

`default_nettype wire

/* hdl/cla_adder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module cla_adder (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic             cin,
    output logic [`XLEN-1:0] sum
);
    localparam int BLK_W = 8;
    localparam int N_BLK = `XLEN / BLK_W;

    // Carry into each 8-bit block
    logic [N_BLK-1:0] blk_cin;

    assign blk_cin[0] = cin;

    for (genvar k = 0; k < N_BLK; k++) begin : g_blk
        logic [BLK_W-1:0] p;
        logic [BLK_W-1:0] g;
        logic [BLK_W-1:0] c;

        assign p = a[k*BLK_W +: BLK_W] ^ b[k*BLK_W +: BLK_W];
        assign g = a[k*BLK_W +: BLK_W] & b[k*BLK_W +: BLK_W];

        assign c[0] = blk_cin[k];

        for (genvar i = 1; i < BLK_W; i++) begin : g_carry
            assign c[i] = g[i-1] | (p[i-1] & c[i-1]);
        end

        assign sum[k*BLK_W +: BLK_W] = p ^ c;

        // Top block has no successor
        if (k < N_BLK - 1) begin : g_next
            assign blk_cin[k+1] = g[BLK_W-1] | (p[BLK_W-1] & c[BLK_W-1]);
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_pkg.sv */
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_lui,
        alu_auipc,
        alu_none
    } alu_fn_e;

    // One decoded instruction as it enters the stage
    typedef struct packed {
        logic [6:0]       opcode;
        logic [2:0]       func3;
        logic [6:0]       func7;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] data1;
        logic [`XLEN-1:0] data2;
        logic [`PC_W-1:0] pc;
    } ex_req_t;

    typedef struct packed {
        alu_fn_e alu_fn;
        logic    word;
        logic    use_imm;
        logic    is_load;
        logic    is_store;
        logic    cond_branch;
        logic    is_jal;
        logic    is_jalr;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`PC_W-1:0] pc_branch;
        logic             is_branch;
        logic             mem_rw;
        logic             is_load;
    } ex_resp_t;

endpackage

`default_nettype wire

/* hdl/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Datapath widths
`define XLEN 64
`define PC_W 32

// RV64I major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_BRANCH    7'b1100011
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_AUIPC     7'b0010111
`define OPC_LUI       7'b0110111

// func3, arithmetic
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// func3, branches
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// func7, ALT picks sub and sra
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

`endif
